/* vc_xy.f */
+incdir+include
design/vc_xy_pkg.sv
design/vc_cmd_ingress.sv
design/vc_route_fifo.sv
design/xy_switch.sv
design/vc_xy_top.sv
tests/vc_xy_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the vc_xy testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vc_xy.f --top-module vc_xy_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vvc_xy_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1

/* include/xy_route_model.svh */
`ifndef XY_ROUTE_MODEL_SVH
`define XY_ROUTE_MODEL_SVH

// reference decode of one command into lane modes
function automatic route_vec_t model_decode(input arb_out_req_t c);
    route_vec_t  rv;
    lane_route_e m;
    m = ROUTE_PASS;
    if (c.direction_id == DIR_NORTH) begin
        m = (c.op == OP_READ) ? ROUTE_RD_N : ROUTE_WR_N;
    end else if (c.direction_id == DIR_SOUTH) begin
        m = (c.op == OP_READ) ? ROUTE_RD_S : ROUTE_WR_S;
    end
    for (int i = 0; i < NUM_LANES; i++) begin
        rv[i] = (c.group_row == c.group_col && c.lane_mask[i]) ? m : ROUTE_PASS;
    end
    return rv;
endfunction

// expected outputs of one beat, before the beat_vld gate
function automatic void model_steer(
    input  route_vec_t rv,
    input  side_bus_t  l,
    input  side_bus_t  r,
    input  side_bus_t  up,
    input  side_bus_t  dn,
    output side_bus_t  o_l,
    output side_bus_t  o_r,
    output side_bus_t  o_up,
    output side_bus_t  o_dn
);
    o_l  = '0;
    o_r  = '0;
    o_up = '0;
    o_dn = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
        case (rv[i])
            ROUTE_RD_N: begin
                o_r.vld[i] = l.vld[i];  o_r.data[i]  = l.data[i];
                o_up.vld[i] = r.vld[i]; o_up.data[i] = r.data[i];
            end
            ROUTE_RD_S: begin
                o_r.vld[i] = l.vld[i];  o_r.data[i]  = l.data[i];
                o_dn.vld[i] = r.vld[i]; o_dn.data[i] = r.data[i];
            end
            ROUTE_WR_N: begin
                o_r.vld[i] = up.vld[i]; o_r.data[i] = up.data[i];
                o_l.vld[i] = r.vld[i];  o_l.data[i] = r.data[i];
            end
            ROUTE_WR_S: begin
                o_r.vld[i] = dn.vld[i]; o_r.data[i] = dn.data[i];
                o_l.vld[i] = r.vld[i];  o_l.data[i] = r.data[i];
            end
            default: begin
                o_r.vld[i] = l.vld[i];  o_r.data[i] = l.data[i];
                o_l.vld[i] = r.vld[i];  o_l.data[i] = r.data[i];
            end
        endcase
    end
endfunction

`endif

/* tests/vc_xy_tb.sv */
`timescale 1ns/1ps

module vc_xy_tb
    import vc_xy_pkg::*;
;

    `include "xy_route_model.svh"

    localparam int RESET_CYCLES   = 16;
    localparam int RUN_CYCLES     = 2000;
    // commands only, no beats, so the credits run dry
    localparam int FILL_CYCLES    = 12;
    // reset plus run length with roughly a fifth spare
    localparam int TIMEOUT_CYCLES = 2500;

    logic         clk;
    logic         reset;
    logic         cmd_vld;
    arb_out_req_t cmd;
    logic         cmd_ready;
    logic         beat_vld;
    side_bus_t    in_l;
    side_bus_t    in_r;
    side_bus_t    in_up;
    side_bus_t    in_down;
    side_bus_t    out_l;
    side_bus_t    out_r;
    side_bus_t    out_up;
    side_bus_t    out_down;

    // reference state, always one edge ahead of the DUT
    route_vec_t ref_q[$];
    int         credits;
    logic       ret_pend;
    logic       exp_beat;
    side_bus_t  exp_l;
    side_bus_t  exp_r;
    side_bus_t  exp_up;
    side_bus_t  exp_dn;
    int         errors;
    int         checks;
    int         cycles = 0;

    vc_xy_top UUT (
        .clk       (clk),
        .reset     (reset),
        .cmd_vld   (cmd_vld),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .beat_vld  (beat_vld),
        .in_l      (in_l),
        .in_r      (in_r),
        .in_up     (in_up),
        .in_down   (in_down),
        .out_l     (out_l),
        .out_r     (out_r),
        .out_up    (out_up),
        .out_down  (out_down)
    );

    always #5 clk = ~clk;

    // hang guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // random words, valids limited to the allowed lanes
    task automatic random_side(output side_bus_t s, input lane_mask_t allow);
        s.vld = lane_mask_t'($urandom) & allow;
        for (int i = 0; i < NUM_LANES; i++) begin
            s.data[i] = $urandom;
        end
    endtask

    task automatic drive_cycle(input bit fill);
        route_vec_t head;
        lane_mask_t wr_lanes;
        for (int i = 0; i < NUM_LANES; i++) begin
            head[i] = ROUTE_PASS;
        end
        if (ref_q.size() > 0) begin
            head = ref_q[0];
        end
        // vertical inputs only where the beat will write
        for (int i = 0; i < NUM_LANES; i++) begin
            wr_lanes[i] = (head[i] == ROUTE_WR_N || head[i] == ROUTE_WR_S);
        end
        cmd_vld = fill ? 1'b1 : ($urandom_range(0, 99) < 60);
        beat_vld = fill ? 1'b0 : ($urandom_range(0, 99) < 50);
        cmd.op = ($urandom_range(0, 1) == 0) ? OP_READ : OP_WRITE;
        cmd.lane_mask = lane_mask_t'($urandom);
        cmd.direction_id = direction_id_t'($urandom_range(0, 3));
        cmd.group_row = group_id_t'($urandom_range(0, 3));
        // mostly diagonal, some off-diagonal
        cmd.group_col = ($urandom_range(0, 3) == 0) ?
            group_id_t'($urandom_range(0, 3)) : cmd.group_row;
        random_side(in_l, '1);
        random_side(in_r, '1);
        random_side(in_up, wr_lanes);
        random_side(in_down, wr_lanes);
    endtask

    // advance the reference by the coming edge
    task automatic model_step();
        route_vec_t rv;
        logic       acc;
        logic       popped;
        acc = cmd_vld && (credits != 0);
        popped = beat_vld && (ref_q.size() > 0);
        for (int i = 0; i < NUM_LANES; i++) begin
            rv[i] = ROUTE_PASS;
        end
        // head seen by the beat excludes this edge's accept
        if (popped) begin
            rv = ref_q.pop_front();
        end
        model_steer(rv, in_l, in_r, in_up, in_down, exp_l, exp_r, exp_up, exp_dn);
        exp_beat = beat_vld;
        if (!beat_vld) begin
            exp_l.vld  = '0;
            exp_r.vld  = '0;
            exp_up.vld = '0;
            exp_dn.vld = '0;
        end
        // credit comes back one edge after the pop
        credits = credits - (acc ? 1 : 0) + (ret_pend ? 1 : 0);
        ret_pend = popped;
        if (acc) begin
            ref_q.push_back(model_decode(cmd));
        end
    endtask

    task automatic check_outputs();
        checks++;
        assert (cmd_ready == (credits != 0)) else begin
            errors++;
            $display("CHECK FAILED at %0t: cmd_ready %0b with %0d credits",
                     $time, cmd_ready, credits);
        end
        checks++;
        assert ({out_l.vld, out_r.vld, out_up.vld, out_down.vld} ==
                {exp_l.vld, exp_r.vld, exp_up.vld, exp_dn.vld}) else begin
            errors++;
            $display("CHECK FAILED at %0t: valids l/r/up/dn %h %h %h %h, expected %h %h %h %h",
                     $time, out_l.vld, out_r.vld, out_up.vld, out_down.vld,
                     exp_l.vld, exp_r.vld, exp_up.vld, exp_dn.vld);
        end
        // words only matter after a beat
        if (exp_beat) begin
            checks++;
            assert ({out_l.data, out_r.data, out_up.data, out_down.data} ==
                    {exp_l.data, exp_r.data, exp_up.data, exp_dn.data}) else begin
                errors++;
                $display("CHECK FAILED at %0t: steered data words differ from model", $time);
            end
        end
    endtask

    initial begin
        void'($urandom(32'hb458_c3d7));
        clk = 1'b0;
        reset = 1'b1;
        cmd_vld = 1'b0;
        cmd = '0;
        beat_vld = 1'b0;
        in_l = '0;
        in_r = '0;
        in_up = '0;
        in_down = '0;
        errors = 0;
        checks = 0;
        credits = ROUTE_DEPTH;
        ret_pend = 1'b0;
        exp_beat = 1'b0;
        exp_l = '0;
        exp_r = '0;
        exp_up = '0;
        exp_dn = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        // ready high, valids low straight out of reset
        check_outputs();
        for (int n = 0; n < RUN_CYCLES; n++) begin
            drive_cycle(n < FILL_CYCLES);
            model_step();
            @(posedge clk);
            #1;
            check_outputs();
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* design/vc_xy_top.sv */
`timescale 1ns/1ps

module vc_xy_top
    import vc_xy_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    // command port
    input  logic         cmd_vld,
    input  arb_out_req_t cmd,
    output logic         cmd_ready,
    // data beat
    input  logic         beat_vld,
    input  side_bus_t    in_l,
    input  side_bus_t    in_r,
    input  side_bus_t    in_up,
    input  side_bus_t    in_down,
    output side_bus_t    out_l,
    output side_bus_t    out_r,
    output side_bus_t    out_up,
    output side_bus_t    out_down
);

    // ingress to fifo
    logic       push;
    route_vec_t push_route;
    logic       credit_ret;
    // fifo to switch
    logic       pop;
    logic       head_vld;
    route_vec_t head_route;

    vc_cmd_ingress u_ingress (
        .clk        (clk),
        .reset      (reset),
        .cmd_vld    (cmd_vld),
        .cmd        (cmd),
        .cmd_ready  (cmd_ready),
        .push       (push),
        .push_route (push_route),
        .credit_ret (credit_ret)
    );

    vc_route_fifo u_fifo (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .push_route (push_route),
        .pop        (pop),
        .head_vld   (head_vld),
        .head_route (head_route),
        .credit_ret (credit_ret)
    );

    xy_switch u_switch (
        .clk        (clk),
        .reset      (reset),
        .beat_vld   (beat_vld),
        .head_vld   (head_vld),
        .head_route (head_route),
        .pop        (pop),
        .in_l       (in_l),
        .in_r       (in_r),
        .in_up      (in_up),
        .in_down    (in_down),
        .out_l      (out_l),
        .out_r      (out_r),
        .out_up     (out_up),
        .out_down   (out_down)
    );

endmodule

/* design/xy_switch.sv */
`timescale 1ns/1ps

module xy_switch
    import vc_xy_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       beat_vld,
    input  logic       head_vld,
    input  route_vec_t head_route,
    output logic       pop,
    input  side_bus_t  in_l,
    input  side_bus_t  in_r,
    input  side_bus_t  in_up,
    input  side_bus_t  in_down,
    output side_bus_t  out_l,
    output side_bus_t  out_r,
    output side_bus_t  out_up,
    output side_bus_t  out_down
);

    // steered values ahead of the output flops
    side_bus_t nxt_l;
    side_bus_t nxt_r;
    side_bus_t nxt_up;
    side_bus_t nxt_down;

    // each beat consumes one queued route if there is one
    assign pop = beat_vld && head_vld;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        lane_route_e mode;
        logic        r_from_up;
        logic        r_from_dn;
        logic        l_on;
        logic        up_on;
        logic        dn_on;

        // empty queue falls back to pass
        assign mode = head_vld ? head_route[i] : ROUTE_PASS;

        always_comb begin
            r_from_up = 1'b0;
            r_from_dn = 1'b0;
            l_on      = 1'b1;
            up_on     = 1'b0;
            dn_on     = 1'b0;
            case (mode)
                // reads pull the right input onto the vertical port
                ROUTE_RD_N: begin
                    l_on  = 1'b0;
                    up_on = 1'b1;
                end
                ROUTE_RD_S: begin
                    l_on  = 1'b0;
                    dn_on = 1'b1;
                end
                // writes push vertical data out to the right
                ROUTE_WR_N: r_from_up = 1'b1;
                ROUTE_WR_S: r_from_dn = 1'b1;
                default: ;
            endcase
        end

        // right output always has a source
        assign nxt_r.vld[i]  = r_from_up ? in_up.vld[i] :
                               r_from_dn ? in_down.vld[i] : in_l.vld[i];
        assign nxt_r.data[i] = r_from_up ? in_up.data[i] :
                               r_from_dn ? in_down.data[i] : in_l.data[i];

        // the others carry the right input or zero
        assign nxt_l.vld[i]     = l_on && in_r.vld[i];
        assign nxt_l.data[i]    = l_on ? in_r.data[i] : '0;
        assign nxt_up.vld[i]    = up_on && in_r.vld[i];
        assign nxt_up.data[i]   = up_on ? in_r.data[i] : '0;
        assign nxt_down.vld[i]  = dn_on && in_r.vld[i];
        assign nxt_down.data[i] = dn_on ? in_r.data[i] : '0;

        // vertical inputs only arrive for write routes
        a_vert_in_write: assert property (@(posedge clk) disable iff (reset)
            beat_vld && (in_up.vld[i] || in_down.vld[i]) |->
                (mode == ROUTE_WR_N || mode == ROUTE_WR_S));
    end

    // valids clear on reset or when no beat comes
    always_ff @(posedge clk) begin
        out_l.data    <= nxt_l.data;
        out_r.data    <= nxt_r.data;
        out_up.data   <= nxt_up.data;
        out_down.data <= nxt_down.data;
        if (reset || !beat_vld) begin
            out_l.vld    <= '0;
            out_r.vld    <= '0;
            out_up.vld   <= '0;
            out_down.vld <= '0;
        end else begin
            out_l.vld    <= nxt_l.vld;
            out_r.vld    <= nxt_r.vld;
            out_up.vld   <= nxt_up.vld;
            out_down.vld <= nxt_down.vld;
        end
    end

endmodule

/* design/vc_route_fifo.sv */
`timescale 1ns/1ps

module vc_route_fifo
    import vc_xy_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       push,
    input  route_vec_t push_route,
    input  logic       pop,
    output logic       head_vld,
    output route_vec_t head_route,
    output logic       credit_ret
);

    // route storage
    route_vec_t          mem [ROUTE_DEPTH];
    logic [PTR_W-1:0]    rd_ptr;
    logic [PTR_W-1:0]    wr_ptr;
    logic [CREDIT_W-1:0] count;

    assign head_vld   = (count != '0);
    assign head_route = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_route;
        end
    end

    // pointers wrap naturally at depth 4
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + CREDIT_W'(1);
                2'b01:   count <= count - CREDIT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // one credit back to ingress per pop, a cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_ret <= 1'b0;
        end else begin
            credit_ret <= pop;
        end
    end

    // ingress credits must keep a full queue from taking a push
    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        !(push && count == CREDIT_W'(ROUTE_DEPTH)));

    // switch only pops a valid head
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        !(pop && count == '0));

endmodule

/* design/vc_cmd_ingress.sv */
`timescale 1ns/1ps

module vc_cmd_ingress
    import vc_xy_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         cmd_vld,
    input  arb_out_req_t cmd,
    output logic         cmd_ready,
    output logic         push,
    output route_vec_t   push_route,
    input  logic         credit_ret
);

    logic [CREDIT_W-1:0] credit_cnt;
    logic                on_diag;
    lane_route_e         lane_mode;

    // diagonal block only when row and column groups agree
    assign on_diag = (cmd.group_row == cmd.group_col);

    // mode that masked lanes take
    always_comb begin
        lane_mode = ROUTE_PASS;
        if (cmd.direction_id == DIR_NORTH) begin
            if (cmd.op == OP_READ) begin
                lane_mode = ROUTE_RD_N;
            end else begin
                lane_mode = ROUTE_WR_N;
            end
        end else if (cmd.direction_id == DIR_SOUTH) begin
            if (cmd.op == OP_READ) begin
                lane_mode = ROUTE_RD_S;
            end else begin
                lane_mode = ROUTE_WR_S;
            end
        end
    end

    // off diagonal or unmasked lanes stay pass-through
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (on_diag && cmd.lane_mask[i]) begin
                push_route[i] = lane_mode;
            end else begin
                push_route[i] = ROUTE_PASS;
            end
        end
    end

    // ready while the FIFO still has room
    assign cmd_ready = (credit_cnt != '0);
    assign push      = cmd_vld && cmd_ready;

    // push spends a credit, credit_ret gives one back
    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= CREDIT_W'(ROUTE_DEPTH);
        end else begin
            case ({push, credit_ret})
                2'b10:   credit_cnt <= credit_cnt - CREDIT_W'(1);
                2'b01:   credit_cnt <= credit_cnt + CREDIT_W'(1);
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // FIFO never returns more credits than it was given
    a_credit_max: assert property (@(posedge clk) disable iff (reset)
        credit_cnt <= CREDIT_W'(ROUTE_DEPTH));

endmodule

/* design/vc_xy_pkg.sv */
package vc_xy_pkg;

    // slice geometry
    localparam int NUM_LANES   = 8;
    localparam int ROUTE_DEPTH = 4;
    // counts 0 to ROUTE_DEPTH inclusive
    localparam int CREDIT_W    = 3;
    localparam int PTR_W       = $clog2(ROUTE_DEPTH);

    typedef logic [31:0]          lane_word_t;
    typedef logic [NUM_LANES-1:0] lane_mask_t;
    typedef logic [1:0]           group_id_t;
    // 0 west, 1 east, 2 south, 3 north
    typedef logic [1:0]           direction_id_t;

    // only the vertical directions steer anything
    localparam direction_id_t DIR_SOUTH = 2'd2;
    localparam direction_id_t DIR_NORTH = 2'd3;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } cache_op_e;

    // per lane steering mode
    typedef enum logic [2:0] {
        ROUTE_PASS,
        ROUTE_RD_N,
        ROUTE_RD_S,
        ROUTE_WR_N,
        ROUTE_WR_S
    } lane_route_e;

    typedef lane_route_e [NUM_LANES-1:0] route_vec_t;

    // command from the arbiter
    typedef struct packed {
        cache_op_e     op;
        lane_mask_t    lane_mask;
        direction_id_t direction_id;
        group_id_t     group_row;
        group_id_t     group_col;
    } arb_out_req_t;

    // one side port, valid mask plus one word per lane
    typedef struct packed {
        lane_mask_t                    vld;
        lane_word_t [NUM_LANES-1:0]    data;
    } side_bus_t;

endpackage
